// ==== mips_cpu_harvard.f ====
+incdir+.
mips_pkg.sv
mips_rf_if.sv
mips_decoder.sv
mips_reg_file.sv
mips_execute.sv
mips_pc_unit.sv
mips_cpu_harvard.sv
mips_cpu_harvard_sva.sv
mips_cpu_harvard_tb.sv

// ==== Makefile ====
TOP := mips_cpu_harvard_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on errors"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): mips_cpu_harvard.f *.sv *.svh
	verilator --binary --timing --assert --top-module $(TOP) -f mips_cpu_harvard.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; echo "simulator exit status $$?" >> sim.log
	@cat sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "simulator exit status 0" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== mips_cpu_harvard_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mips_cfg.svh"

module mips_cpu_harvard_tb;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_TESTS  = 5;
	localparam int PROG_LEN   = 20;
	localparam int RAM_WORDS  = 16;
	// word preloaded and checked by every test, byte address 12
	localparam int CHECK_IDX  = 3;
	localparam int SEED       = 32'h1b86_8c3b;

	// register numbers
	localparam logic [4:0] ZERO = 5'd0,
		V0 = 5'd2,
		T0 = 5'd8,
		T1 = 5'd9,
		T2 = 5'd10,
		T3 = 5'd11,
		T4 = 5'd12,
		T5 = 5'd13,
		T6 = 5'd14,
		T7 = 5'd15,
		RA = 5'd31;

	// MIPS32 primary opcodes
	localparam logic [5:0] OP_J = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b;

	// SPECIAL function codes
	localparam logic [5:0] FN_SLL = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b;

	// fetched outside the program, so at address 0 once halted
	// each would change v0 or the checked word if it ran
	localparam logic [31:0] HALT_ADD   = {OP_ADDIU, V0, V0, 16'd1};
	localparam logic [31:0] HALT_STORE = {OP_SW, ZERO, V0, 16'd12};

	logic        clk;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;

	// test table
	logic [31:0] prog [NUM_TESTS][PROG_LEN];
	logic [31:0] init_word [NUM_TESTS];
	logic [31:0] en_seed [NUM_TESTS];
	logic [31:0] exp_v0 [NUM_TESTS];
	logic [31:0] exp_word [NUM_TESTS];

	logic [31:0] rom [PROG_LEN];
	logic [31:0] ram [RAM_WORDS];
	logic [31:0] rom_offset;
	logic [31:0] cur_init;
	int          cur_test;
	int          fill_test;
	int          fill_slot;
	int          seed;
	int          checks;
	int          errors;

	mips_cpu_harvard u_dut (
		.clk            (clk),
		.reset          (reset),
		.active         (active),
		.register_v0    (register_v0),
		.clk_enable     (clk_enable),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	bind mips_cpu_harvard mips_cpu_harvard_sva u_sva (
		.clk           (clk),
		.reset         (reset),
		.clk_enable    (clk_enable),
		.active        (active),
		.instr_address (instr_address),
		.data_read     (data_read),
		.data_write    (data_write)
	);

	// instruction ROM from the reset vector up
	// elsewhere a v0 add on even tests, a store on odd ones
	assign rom_offset     = (instr_address - `MIPS_RESET_VECTOR) >> 2;
	assign instr_readdata = (rom_offset < PROG_LEN) ? rom[rom_offset[4:0]]
		: (cur_test[0] ? HALT_STORE : HALT_ADD);

	// data RAM, combinational read, only while data_read is high
	assign data_readdata = data_read ? ram[data_address[5:2]] : 32'h0;

	// refilled under reset, then written on enabled edges
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < RAM_WORDS; i++) begin
				ram[i[3:0]] <= 32'h5a00_0000 | (i << 2);
			end
			ram[CHECK_IDX] <= cur_init;
		end else if (data_write && clk_enable) begin
			ram[data_address[5:2]] <= data_writedata;
		end
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// jump to a slot of the program
	function automatic logic [31:0] j_word(input logic [5:0] op, input int slot);
		logic [31:0] target;
		target = `MIPS_RESET_VECTOR + 32'(slot) * 32'd4;
		return {op, target[27:2]};
	endfunction

	// roughly three enabled cycles in four
	function automatic logic next_enable();
		logic [31:0] rnd;
		rnd = $random(seed);
		return rnd[0] | rnd[1];
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[fill_test[2:0]][fill_slot[4:0]] = word;
		fill_slot++;
	endtask

	task automatic build_table();
		logic [15:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] s;
		logic [31:0] z;
		logic [31:0] u;
		logic [31:0] w;
		logic [31:0] v;
		for (int t = 0; t < NUM_TESTS; t++) begin
			for (int i = 0; i < PROG_LEN; i++) begin
				prog[t[2:0]][i[4:0]] = 32'h0;
			end
		end

		// test 0, ALU ops on a negative and a positive operand
		a = 32'hffff_fff9;
		b = 32'd100;
		fill_test = 0;
		fill_slot = 0;
		emit(i_word(OP_ADDIU, ZERO, T0, 16'hfff9));
		emit(i_word(OP_ADDIU, ZERO, T1, 16'd100));
		emit(r_word(T0, T1, V0, 5'd0, FN_ADDU));
		emit(r_word(T0, T1, T2, 5'd0, FN_SUBU));
		emit(r_word(V0, T2, V0, 5'd0, FN_XOR));
		emit(r_word(T0, T1, T3, 5'd0, FN_AND));
		emit(r_word(T0, T1, T4, 5'd0, FN_OR));
		emit(r_word(T4, T3, T3, 5'd0, FN_SUBU));
		emit(r_word(V0, T3, V0, 5'd0, FN_ADDU));
		emit(r_word(T0, T1, T5, 5'd0, FN_SLT));
		emit(r_word(T0, T1, T6, 5'd0, FN_SLTU));
		// v0 += 2*slt + sltu
		emit(r_word(T5, T5, T5, 5'd0, FN_ADDU));
		emit(r_word(T5, T6, T5, 5'd0, FN_ADDU));
		emit(r_word(V0, T5, V0, 5'd0, FN_ADDU));
		emit(r_word(ZERO, ZERO, ZERO, 5'd0, FN_JR));
		init_word[0] = 32'h1111_2222;
		en_seed[0]   = 32'h0;
		exp_v0[0]    = ((a + b) ^ (a - b)) + ((a | b) - (a & b))
			+ (($signed(a) < $signed(b)) ? 32'd2 : 32'd0) + ((a < b) ? 32'd1 : 32'd0);
		exp_word[0]  = init_word[0];

		// test 1, extension rules, lui and shifts
		imm = 16'h8001;
		s = {{16{imm[15]}}, imm};
		z = {16'h0, imm};
		u = {16'h1234, 16'h0} ^ {16'h0, 16'hf0f0};
		fill_test = 1;
		fill_slot = 0;
		emit(i_word(OP_ADDIU, ZERO, T0, imm));
		emit(i_word(OP_ORI, ZERO, T1, imm));
		emit(r_word(T0, T1, V0, 5'd0, FN_XOR));
		emit(i_word(OP_LUI, ZERO, T2, 16'h1234));
		emit(i_word(OP_XORI, T2, T2, 16'hf0f0));
		emit(r_word(ZERO, T2, T3, 5'd8, FN_SLL));
		emit(r_word(V0, T3, V0, 5'd0, FN_XOR));
		emit(i_word(OP_ANDI, T0, T4, 16'hff00));
		emit(r_word(V0, T4, V0, 5'd0, FN_ADDU));
		emit(r_word(ZERO, T0, T5, 5'd4, FN_SRA));
		emit(r_word(V0, T5, V0, 5'd0, FN_XOR));
		emit(r_word(ZERO, T0, T6, 5'd28, FN_SRL));
		emit(r_word(V0, T6, V0, 5'd0, FN_ADDU));
		emit(i_word(OP_SLTI, T0, T7, 16'd1));
		emit(r_word(V0, T7, V0, 5'd0, FN_ADDU));
		emit(r_word(ZERO, ZERO, ZERO, 5'd0, FN_JR));
		// sign bit fills from the left
		w = $signed(s) >>> 4;
		v = (s ^ z) ^ (u << 8);
		v = v + (s & {16'h0, 16'hff00});
		v = v ^ w;
		v = v + (s >> 28);
		v = v + (($signed(s) < 32'sd1) ? 32'd1 : 32'd0);
		init_word[1] = 32'h2222_3333;
		en_seed[1]   = 32'h0000_0011;
		exp_v0[1]    = v;
		exp_word[1]  = init_word[1];

		// test 2, preloaded load, store/load round trip, store back
		fill_test = 2;
		fill_slot = 0;
		emit(i_word(OP_LW, ZERO, V0, 16'd12));
		emit(i_word(OP_ADDIU, ZERO, T0, 16'h1357));
		emit(i_word(OP_LUI, ZERO, T1, 16'h2468));
		emit(r_word(T1, T0, T1, 5'd0, FN_OR));
		emit(i_word(OP_SW, ZERO, T1, 16'd20));
		emit(i_word(OP_LW, ZERO, T2, 16'd20));
		emit(r_word(V0, T2, V0, 5'd0, FN_ADDU));
		emit(i_word(OP_ADDIU, ZERO, T3, 16'd8));
		// base 8 plus offset 4, the checked word
		emit(i_word(OP_SW, T3, V0, 16'd4));
		emit(r_word(ZERO, ZERO, ZERO, 5'd0, FN_JR));
		init_word[2] = 32'h0bad_f00d;
		en_seed[2]   = 32'h0000_0022;
		exp_v0[2]    = init_word[2] + ({16'h2468, 16'h0} | {16'h0, 16'h1357});
		exp_word[2]  = exp_v0[2];

		// test 3, each marker bit in v0 is one path
		fill_test = 3;
		fill_slot = 0;
		emit(i_word(OP_ADDIU, ZERO, T0, 16'd5));
		emit(i_word(OP_ADDIU, ZERO, T1, 16'd5));
		emit(i_word(OP_BEQ, T0, T1, 16'd1));
		emit(i_word(OP_ORI, V0, V0, 16'h001));
		emit(i_word(OP_ORI, V0, V0, 16'h002));
		emit(i_word(OP_BEQ, T0, ZERO, 16'd1));
		emit(i_word(OP_ORI, V0, V0, 16'h004));
		emit(i_word(OP_BNE, T0, T1, 16'd1));
		emit(i_word(OP_ORI, V0, V0, 16'h008));
		emit(i_word(OP_BNE, T0, ZERO, 16'd1));
		emit(i_word(OP_ORI, V0, V0, 16'h010));
		emit(j_word(OP_JAL, 15));
		emit(i_word(OP_ORI, V0, V0, 16'h020));
		emit(j_word(OP_J, 17));
		emit(i_word(OP_ORI, V0, V0, 16'h040));
		// subroutine at slot 15
		emit(i_word(OP_ORI, V0, V0, 16'h080));
		emit(r_word(RA, ZERO, ZERO, 5'd0, FN_JR));
		emit(r_word(ZERO, ZERO, ZERO, 5'd0, FN_JR));
		init_word[3] = 32'h4444_5555;
		en_seed[3]   = 32'h0000_0033;
		exp_v0[3]    = 32'h002 | 32'h004 | 32'h008 | 32'h020 | 32'h080;
		exp_word[3]  = init_word[3];

		// test 4, test 0 again under another enable pattern
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[4][i[4:0]] = prog[0][i[4:0]];
		end
		init_word[4] = 32'h6666_7777;
		en_seed[4]   = 32'h0000_5a5a;
		exp_v0[4]    = exp_v0[0];
		exp_word[4]  = init_word[4];
	endtask

	task automatic check_value(input int t, input string what, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			$display("Fail %0t: test %0d %s is %h, expected %h", $time, t, what, got,
				expected);
			errors++;
		end
	endtask

	task automatic run_test(input int t);
		logic [31:0] hold;
		for (int i = 0; i < PROG_LEN; i++) begin
			rom[i[4:0]] = prog[t[2:0]][i[4:0]];
		end
		cur_test = t;
		cur_init = init_word[t[2:0]];
		seed = SEED ^ en_seed[t[2:0]];
		reset = 1'b1;
		clk_enable = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		// random stalls until the jump to address 0
		while (active) begin
			clk_enable = next_enable();
			@(negedge clk);
		end
		check_value(t, "v0", register_v0, exp_v0[t[2:0]]);
		hold = register_v0;
		// halted core must sit still
		repeat (20) begin
			clk_enable = next_enable();
			@(negedge clk);
			check_value(t, "v0 after halt", register_v0, hold);
			check_value(t, "pc after halt", instr_address, 32'h0);
			checks++;
			assert (!active) else begin
				$display("test %0d: active went high again after the halt", t);
				errors++;
			end
		end
		check_value(t, "data word", ram[CHECK_IDX], exp_word[t[2:0]]);
	endtask

	initial begin
		reset = 1'b1;
		clk_enable = 1'b0;
		cur_init = 32'h0;
		cur_test = 0;
		seed = SEED;
		checks = 0;
		errors = 0;
		build_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// 200 cycles per test covers reset, stalls and the halt window
	initial begin
		#(NUM_TESTS * 200 * CLK_PERIOD);
		$display("watchdog timeout, the CPU did not halt within %0d cycles",
			NUM_TESTS * 200);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mips_cpu_harvard_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mips_cfg.svh"

module mips_cpu_harvard_sva (
	input logic        clk,
	input logic        reset,
	input logic        clk_enable,
	input logic        active,
	input logic [31:0] instr_address,
	input logic        data_read,
	input logic        data_write
);

	// one data access per instruction, load or store
	no_read_and_write: assert property (@(posedge clk) !(data_read && data_write))
		else $error("data_read and data_write are high in the same cycle");

	// halted core must not touch memory
	no_write_when_halted: assert property (@(posedge clk) !active |-> !data_write)
		else $error("data_write is high while active is low");

	// fetch restarts at the reset vector
	fetch_from_vector: assert property (@(posedge clk)
		reset |=> instr_address == `MIPS_RESET_VECTOR)
		else $error("instr_address is not the reset vector after reset");

	// a stalled edge leaves the pc alone
	pc_holds_on_stall: assert property (@(posedge clk) disable iff (reset)
		!clk_enable |=> $stable(instr_address))
		else $error("instr_address moved while clk_enable was low");

endmodule

`default_nettype wire

// ==== mips_cpu_harvard.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mips_cfg.svh"

module mips_cpu_harvard (
	input  logic                  clk,
	input  logic                  reset,
	output logic                  active,
	output logic [`MIPS_XLEN-1:0] register_v0,

	// stall by dropping this, nothing advances while low
	input  logic                  clk_enable,

	// instruction port, combinational read
	output logic [`MIPS_XLEN-1:0] instr_address,
	input  logic [`MIPS_XLEN-1:0] instr_readdata,

	// data port, combinational read and single-cycle write
	output logic [`MIPS_XLEN-1:0] data_address,
	output logic                  data_write,
	output logic                  data_read,
	output logic [`MIPS_XLEN-1:0] data_writedata,
	input  logic [`MIPS_XLEN-1:0] data_readdata
);

	mips_pkg::instr_t      instr;
	mips_pkg::ctrl_t       ctrl;
	logic                  branch_taken;
	logic [`MIPS_XLEN-1:0] jump_target;
	logic [`MIPS_XLEN-1:0] link_address;

	// fetched word viewed as R/I/J fields
	assign instr = mips_pkg::instr_t'(instr_readdata);

	mips_rf_if rf ();

	mips_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl),
		.rf    (rf.decode)
	);

	mips_reg_file u_reg_file (
		.clk         (clk),
		.reset       (reset),
		.clk_enable  (clk_enable),
		.rf          (rf.regs),
		.register_v0 (register_v0)
	);

	mips_execute u_execute (
		.instr          (instr),
		.ctrl           (ctrl),
		.active         (active),
		.reset          (reset),
		.link_address   (link_address),
		.rf             (rf.exec),
		.data_address   (data_address),
		.data_writedata (data_writedata),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_readdata  (data_readdata),
		.branch_taken   (branch_taken),
		.jump_target    (jump_target)
	);

	mips_pc_unit u_pc_unit (
		.clk           (clk),
		.reset         (reset),
		.clk_enable    (clk_enable),
		.instr         (instr),
		.ctrl          (ctrl),
		.branch_taken  (branch_taken),
		.jump_target   (jump_target),
		.instr_address (instr_address),
		.link_address  (link_address),
		.active        (active)
	);

endmodule

`default_nettype wire

// ==== mips_pc_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mips_cfg.svh"

module mips_pc_unit (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  clk_enable,
	input  mips_pkg::instr_t      instr,
	input  mips_pkg::ctrl_t       ctrl,
	input  logic                  branch_taken,
	input  logic [`MIPS_XLEN-1:0] jump_target,
	output logic [`MIPS_XLEN-1:0] instr_address,
	output logic [`MIPS_XLEN-1:0] link_address,
	output logic                  active
);

	logic [`MIPS_XLEN-1:0] pc_plus4;
	logic [`MIPS_XLEN-1:0] branch_address;
	logic [`MIPS_XLEN-1:0] jump_address;
	logic [`MIPS_XLEN-1:0] next_pc;

	assign pc_plus4     = instr_address + 32'd4;
	// jal saves the sequential address, no delay slot
	assign link_address = pc_plus4;

	// word offset relative to pc + 4
	assign branch_address = pc_plus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

	// region bits kept from pc + 4
	assign jump_address = {pc_plus4[31:28], instr.j.target, 2'b00};

	always_comb begin
		case (ctrl.pc_sel)
			mips_pkg::PC_BRANCH: next_pc = branch_taken ? branch_address : pc_plus4;
			mips_pkg::PC_JUMP:   next_pc = jump_address;
			mips_pkg::PC_JREG:   next_pc = jump_target;
			default:             next_pc = pc_plus4;
		endcase
	end

	// once halted the pc sits at 0 until the next reset
	always_ff @(posedge clk) begin
		if (reset) begin
			instr_address <= `MIPS_RESET_VECTOR;
			active        <= 1'b1;
		end else if (clk_enable && active) begin
			instr_address <= next_pc;
			// transfer to address 0 ends the run
			if (next_pc == '0) begin
				active <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== mips_execute.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mips_cfg.svh"

module mips_execute (
	input  mips_pkg::instr_t      instr,
	input  mips_pkg::ctrl_t       ctrl,
	input  logic                  active,
	input  logic                  reset,
	input  logic [`MIPS_XLEN-1:0] link_address,
	mips_rf_if.exec               rf,
	output logic [`MIPS_XLEN-1:0] data_address,
	output logic [`MIPS_XLEN-1:0] data_writedata,
	output logic                  data_write,
	output logic                  data_read,
	input  logic [`MIPS_XLEN-1:0] data_readdata,
	output logic                  branch_taken,
	output logic [`MIPS_XLEN-1:0] jump_target
);

	logic [`MIPS_XLEN-1:0] imm_ext;
	logic [`MIPS_XLEN-1:0] operand_a;
	logic [`MIPS_XLEN-1:0] operand_b;
	logic [`MIPS_XLEN-1:0] alu_result;
	logic                  lt_signed;
	logic                  lt_unsigned;
	logic                  rs_eq_rt;

	// andi/ori/xori zero extend, everything else sign extends
	assign imm_ext = ctrl.zero_ext ? {16'b0, instr.i.imm}
		: {{16{instr.i.imm[15]}}, instr.i.imm};

	assign operand_a = rf.rs_data;
	assign operand_b = ctrl.use_imm ? imm_ext : rf.rt_data;

	assign lt_signed   = $signed(operand_a) < $signed(operand_b);
	assign lt_unsigned = operand_a < operand_b;

	always_comb begin
		case (ctrl.alu_op)
			mips_pkg::ALU_ADD:  alu_result = operand_a + operand_b;
			mips_pkg::ALU_SUB:  alu_result = operand_a - operand_b;
			mips_pkg::ALU_AND:  alu_result = operand_a & operand_b;
			mips_pkg::ALU_OR:   alu_result = operand_a | operand_b;
			mips_pkg::ALU_XOR:  alu_result = operand_a ^ operand_b;
			mips_pkg::ALU_SLT:  alu_result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
			mips_pkg::ALU_SLTU: alu_result = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};
			// shifts act on rt by the shamt field, rs unused
			mips_pkg::ALU_SLL:  alu_result = rf.rt_data << instr.r.shamt;
			mips_pkg::ALU_SRL:  alu_result = rf.rt_data >> instr.r.shamt;
			mips_pkg::ALU_SRA:  alu_result = $signed(rf.rt_data) >>> instr.r.shamt;
			mips_pkg::ALU_LUI:  alu_result = {instr.i.imm, 16'b0};
			default:            alu_result = '0;
		endcase
	end

	// lw/sw decode to ADD with the sign extended offset
	assign data_address   = alu_result;
	assign data_writedata = rf.rt_data;

	// no memory traffic during reset or after halt
	assign data_write = ctrl.mem_write && active && !reset;
	assign data_read  = ctrl.mem_read && active && !reset;

	// write-back mux
	always_comb begin
		case (ctrl.wb_sel)
			mips_pkg::WB_MEM:  rf.wr_data = data_readdata;
			mips_pkg::WB_LINK: rf.wr_data = link_address;
			default:           rf.wr_data = alu_result;
		endcase
	end

	assign rf.wr_en   = ctrl.reg_write && active;
	assign rf.wr_addr = ctrl.dst;

	// beq takes on equal, bne on not equal
	assign rs_eq_rt     = rf.rs_data == rf.rt_data;
	assign branch_taken = ctrl.branch_ne ? !rs_eq_rt : rs_eq_rt;

	// jr target is rs as read
	assign jump_target = rf.rs_data;

endmodule

`default_nettype wire

// ==== mips_reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mips_cfg.svh"

module mips_reg_file (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  clk_enable,
	mips_rf_if.regs               rf,
	output logic [`MIPS_XLEN-1:0] register_v0
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

	// r0 never written, so it stays at its reset value of zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (clk_enable && rf.wr_en && rf.wr_addr != 5'd0) begin
			regs[rf.wr_addr] <= rf.wr_data;
		end
	end

	// combinational reads
	// old value until the edge, new value after it
	assign rf.rs_data = (rf.rs_addr == 5'd0) ? '0 : regs[rf.rs_addr];
	assign rf.rt_data = (rf.rt_addr == 5'd0) ? '0 : regs[rf.rt_addr];

	// v0 for the outside world
	assign register_v0 = regs[2];

endmodule

`default_nettype wire

// ==== mips_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module mips_decoder (
	input  mips_pkg::instr_t instr,
	output mips_pkg::ctrl_t  ctrl,
	mips_rf_if.decode        rf
);

	// both read ports always follow the rs/rt fields
	assign rf.rs_addr = instr.r.rs;
	assign rf.rt_addr = instr.r.rt;

	always_comb begin
		// defaults give a no-op, nothing written anywhere
		ctrl.alu_op    = mips_pkg::ALU_ADD;
		ctrl.use_imm   = 1'b0;
		ctrl.zero_ext  = 1'b0;
		ctrl.mem_read  = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.wb_sel    = mips_pkg::WB_ALU;
		ctrl.branch_ne = 1'b0;
		ctrl.pc_sel    = mips_pkg::PC_SEQ;
		// I-type results go to rt
		ctrl.dst       = instr.i.rt;

		case (instr.r.opcode)
			mips_pkg::OP_SPECIAL: begin
				ctrl.dst       = instr.r.rd;
				ctrl.reg_write = 1'b1;
				case (instr.r.funct)
					mips_pkg::FN_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
					mips_pkg::FN_SRA:  ctrl.alu_op = mips_pkg::ALU_SRA;
					mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::FN_JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.pc_sel    = mips_pkg::PC_JREG;
					end
					// unknown function, drop the write
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			mips_pkg::OP_J: ctrl.pc_sel = mips_pkg::PC_JUMP;
			mips_pkg::OP_JAL: begin
				ctrl.pc_sel    = mips_pkg::PC_JUMP;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = mips_pkg::WB_LINK;
				// return address into ra
				ctrl.dst       = 5'd31;
			end
			mips_pkg::OP_BEQ: ctrl.pc_sel = mips_pkg::PC_BRANCH;
			mips_pkg::OP_BNE: begin
				ctrl.pc_sel    = mips_pkg::PC_BRANCH;
				ctrl.branch_ne = 1'b1;
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI,
			mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				case (instr.i.opcode)
					mips_pkg::OP_SLTI: ctrl.alu_op = mips_pkg::ALU_SLT;
					// logical immediates are zero extended
					mips_pkg::OP_ANDI: begin
						ctrl.alu_op   = mips_pkg::ALU_AND;
						ctrl.zero_ext = 1'b1;
					end
					mips_pkg::OP_ORI: begin
						ctrl.alu_op   = mips_pkg::ALU_OR;
						ctrl.zero_ext = 1'b1;
					end
					mips_pkg::OP_XORI: begin
						ctrl.alu_op   = mips_pkg::ALU_XOR;
						ctrl.zero_ext = 1'b1;
					end
					mips_pkg::OP_LUI: ctrl.alu_op = mips_pkg::ALU_LUI;
					default: ctrl.alu_op = mips_pkg::ALU_ADD;
				endcase
			end
			// address = rs + sign extended offset, through the adder
			mips_pkg::OP_LW: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = mips_pkg::WB_MEM;
			end
			mips_pkg::OP_SW: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			default: ctrl.pc_sel = mips_pkg::PC_SEQ;
		endcase
	end

endmodule

`default_nettype wire

// ==== mips_rf_if.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mips_cfg.svh"

interface mips_rf_if;

	// read ports, addressed straight from the instruction
	logic [4:0]            rs_addr;
	logic [4:0]            rt_addr;
	logic [`MIPS_XLEN-1:0] rs_data;
	logic [`MIPS_XLEN-1:0] rt_data;

	// single write port
	logic                  wr_en;
	logic [4:0]            wr_addr;
	logic [`MIPS_XLEN-1:0] wr_data;

	modport decode (output rs_addr, output rt_addr);

	modport regs (
		input  rs_addr, rt_addr, wr_en, wr_addr, wr_data,
		output rs_data, rt_data
	);

	modport exec (input rs_data, rt_data, output wr_en, wr_addr, wr_data);

endinterface

`default_nettype wire

// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// function field for SPECIAL, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	// next pc source
	typedef enum logic [1:0] {
		PC_SEQ, PC_BRANCH, PC_JUMP, PC_JREG
	} pc_sel_e;

	// write-back source
	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_LINK
	} wb_sel_e;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_fields_t;

	// one fetched word, read through whichever format applies
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} instr_t;

	// decoded control for one instruction
	typedef struct packed {
		alu_op_e    alu_op;
		logic       use_imm;
		logic       zero_ext;
		logic       mem_read;
		logic       mem_write;
		logic       reg_write;
		wb_sel_e    wb_sel;
		logic       branch_ne;
		pc_sel_e    pc_sel;
		// destination register, rd / rt / 31
		logic [4:0] dst;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// core-wide constants shared by RTL and testbench

// first fetch address after reset
`define MIPS_RESET_VECTOR 32'hbfc00000

// architectural register count, r0 hardwired to zero
`define MIPS_REG_COUNT 32

// datapath and address width
`define MIPS_XLEN 32

`endif
